/* Bender.yml */
package:
  name: arcade_io

sources:
  - include_dirs:
      - src
    files:
      - src/arcade_pkg.sv
      - src/cfg_regs.sv
      - src/control_mapper.sv
      - src/blank_timer.sv
      - src/speech_iir.sv
      - src/audio_mixer.sv
      - src/arcade_io_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/tb_arcade_io.sv

/* bench/tb_arcade_io.sv */
// Arcade I/O testbench
// Drives the config bus, player controls, sync pulses and audio inputs
// of the top level and checks each output against its reference rule

`default_nettype none
`timescale 1ns/1ps
`include "arcade_defs.svh"

module tb_arcade_io;
	import arcade_pkg::*;

	localparam int CYCLE_LIMIT = 400000;
	localparam int LINE_LEN = 720;
	localparam int FRAME_LINES = 262;
	localparam int SETTLE_TICKS = 64;

	logic clk_sys;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [`ARC_WB_ADDR_W-1:0] wb_adr;
	logic [`ARC_WB_DATA_W-1:0] wb_dat_w;
	logic [`ARC_WB_DATA_W-1:0] wb_dat_r;
	logic wb_ack;
	player_t p1;
	player_t p2;
	sys_buttons_t sys;
	stick_axis_t stick_x;
	stick_axis_t stick_y;
	logic hs;
	logic vs;
	logic [7:0] sound;
	logic [15:0] speech;
	cab_ports_t cab;
	logic landscape;
	logic hblank;
	logic vblank;
	logic ce_pix;
	logic [15:0] audio_out;
	integer seed;
	int cycles = 0;

	arcade_io_top dut (.*);

	initial
	begin
		clk_sys = 1'b0;
		forever
			#4 clk_sys = ~clk_sys;
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic expect_equal(input string test, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else
			stop_on_error($sformatf("Fail %s expected 0x%0h actual 0x%0h", test, exp, act));
	endtask

	// Audio output within two steps of the expected value
	task automatic expect_near(input string test, input int exp_val);
		int diff;
		diff = int'(audio_out) - exp_val;
		assert (diff <= 2 && diff >= -2)
		else
			stop_on_error($sformatf("Fail %s expected 0x%0h actual 0x%0h",
				test, exp_val, audio_out));
	endtask

	always @(posedge clk_sys)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
			stop_on_error("Timeout: the run went past its cycle limit");
	end

	// Ack is a single-cycle pulse answering a strobe
	ack_pulse: assert property (@(posedge clk_sys) disable iff (rst) wb_ack |=> !wb_ack)
		else stop_on_error("Wishbone ack stayed high for two cycles");
	ack_source: assert property (@(posedge clk_sys) disable iff (rst)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else stop_on_error("Wishbone ack came without a strobe the cycle before");

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	//////////////////////////////////////////////////
	// Reference rules
	//////////////////////////////////////////////////

	function automatic logic [3:0] move_nibble(input player_t p);
		return {p.right, p.left, p.down, p.up};
	endfunction

	// 49-way table with a level of -3..3 from the axis thresholds
	function automatic logic [3:0] stick_zone(input stick_axis_t axis, input logic mirror);
		int v;
		int lvl;
		v = axis;
		if (v < -96)
			lvl = -3;
		else if (v < -64)
			lvl = -2;
		else if (v < -32)
			lvl = -1;
		else if (v > 96)
			lvl = 3;
		else if (v > 64)
			lvl = 2;
		else if (v > 32)
			lvl = 1;
		else
			lvl = 0;
		if (mirror)
			lvl = -lvl;
		case (lvl)
			-3: return 4'd0;
			-2: return 4'd4;
			-1: return 4'd6;
			1: return 4'd11;
			2: return 4'd9;
			3: return 4'd8;
			default: return 4'd7;
		endcase
	endfunction

	function automatic logic [3:0] digital_pos(input logic neg, input logic pos);
		return neg ? 4'd0 : pos ? 4'd8 : 4'd7;
	endfunction

	function automatic int mix_rule(input logic [7:0] snd, input logic [15:0] sp);
		logic [16:0] total;
		total = {snd, 8'd0} + sp;
		return int'(total >> 3);
	endfunction

	//////////////////////////////////////////////////
	// Wishbone master
	//////////////////////////////////////////////////

	task automatic single_access(input logic we, input logic [1:0] adr, input logic [7:0] wdata,
		output logic [7:0] rdata);
		int waited;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		waited = 0;
		do
		begin
			@(negedge clk_sys);
			waited++;
		end
		while (!wb_ack && waited < 16);
		if (!wb_ack)
			stop_on_error("Wishbone ack never arrived");
		expect_equal("bus_ack_delay", 1, waited);
		rdata = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		@(negedge clk_sys);
		expect_equal("bus_ack_drop", 0, wb_ack);
	endtask

	task automatic write_reg(input logic [1:0] adr, input logic [7:0] data);
		logic [7:0] unused;
		single_access(1'b1, adr, data, unused);
	endtask

	task automatic read_reg(input logic [1:0] adr, output logic [7:0] data);
		single_access(1'b0, adr, 8'h00, data);
	endtask

	task automatic set_game(input game_e g);
		write_reg(`ARC_REG_GAME, {5'd0, g});
	endtask

	//////////////////////////////////////////////////
	// Behaviors
	//////////////////////////////////////////////////

	task automatic bus_readback();
		logic [31:0] r;
		logic [7:0] rd;
		int acks;
		read_reg(`ARC_REG_GAME, rd);
		expect_equal("reset_game", 0, rd);
		repeat (4)
		begin
			r = rand_word();
			write_reg(`ARC_REG_GAME, r[7:0]);
			write_reg(`ARC_REG_OPT, r[15:8]);
			write_reg(`ARC_REG_DIP, r[23:16]);
			write_reg(2'd3, r[31:24]);
			read_reg(`ARC_REG_GAME, rd);
			expect_equal("bus_game", {5'd0, r[2:0]}, rd);
			read_reg(`ARC_REG_OPT, rd);
			expect_equal("bus_opt", r[15:8], rd);
			read_reg(`ARC_REG_DIP, rd);
			expect_equal("bus_dip", r[23:16], rd);
			read_reg(2'd3, rd);
			expect_equal("bus_addr3", 0, rd);
		end
		// A strobe held for four cycles makes two accesses
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = `ARC_REG_DIP;
		acks = 0;
		repeat (4)
		begin
			@(negedge clk_sys);
			if (wb_ack)
			begin
				acks++;
				expect_equal("bus_held_read", r[23:16], wb_dat_r);
			end
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		@(negedge clk_sys);
		expect_equal("bus_held_acks", 2, acks);
	endtask

	task automatic joust_ports();
		logic [31:0] r;
		player_t a;
		player_t b;
		sys_buttons_t s;
		logic [2:0] exp_btn;
		set_game(JOUST);
		repeat (40)
		begin
			r = rand_word();
			a = r[9:0];
			b = r[19:10];
			s = r[25:20];
			p1 = a;
			p2 = b;
			sys = s;
			@(negedge clk_sys);
			exp_btn = ~{s.start2, s.start1, s.coin};
			expect_equal("joust_ja", {5'b11111, ~a.fire_a, ~a.right, ~a.left}, cab.ja.buttons);
			expect_equal("joust_jb", {5'b11111, ~b.fire_a, ~b.right, ~b.left}, cab.jb.buttons);
			expect_equal("joust_btn", exp_btn, cab.btn);
			expect_equal("joust_landscape", 1, landscape);
		end
	endtask

	task automatic robotron_ports();
		logic [31:0] r;
		player_t a;
		player_t b;
		player_t ab;
		sys_buttons_t s;
		logic [7:0] dip_val;
		logic [7:0] exp_ja;
		logic [7:0] exp_sw;
		int mode;
		set_game(ROBOTRON);
		r = rand_word();
		dip_val = r[7:0];
		write_reg(`ARC_REG_DIP, dip_val);
		// Twin stick first, then fire buttons, then fire mode
		for (mode = 0; mode < 3; mode++)
		begin
			write_reg(`ARC_REG_OPT, (mode == 0) ? 8'h02 : (mode == 1) ? 8'h00 : 8'h01);
			repeat (20)
			begin
				r = rand_word();
				a = r[9:0];
				b = r[19:10];
				s = r[25:20];
				p1 = a;
				p2 = b;
				sys = s;
				@(negedge clk_sys);
				ab = a | b;
				if (mode == 0)
					exp_ja = ~{move_nibble(b), move_nibble(a)};
				else if (mode == 2)
					exp_ja = ~{move_nibble(ab), move_nibble(ab)};
				else
					exp_ja = ~{ab.fire_a, ab.fire_d, ab.fire_b, ab.fire_c, move_nibble(ab)};
				exp_sw = dip_val | {6'd0, s.advance, s.autoup};
				expect_equal("robotron_ja", exp_ja, cab.ja.buttons);
				expect_equal("robotron_jb", exp_ja, cab.jb.buttons);
				expect_equal("robotron_sw", exp_sw, cab.sw);
			end
		end
	endtask

	task automatic sinistar_stick();
		logic [31:0] r;
		logic [31:0] axes;
		player_t a;
		player_t b;
		player_t pl;
		logic use_p2;
		logic [3:0] ex;
		logic [3:0] ey;
		set_game(SINISTAR);
		sys = '0;
		// Player 1 pushes right so it owns the stick
		p1 = 10'h001;
		p2 = '0;
		stick_x = '0;
		stick_y = '0;
		use_p2 = 1'b0;
		@(negedge clk_sys);
		expect_equal("sinistar_prime_x", 4'h7, cab.ja.stick.x);
		repeat (100)
		begin
			r = rand_word();
			axes = rand_word();
			a = '0;
			b = '0;
			if (r[0])
				b = r[17:8];
			else
				a = r[17:8];
			stick_x = r[1] ? 8'd0 : axes[7:0];
			stick_y = r[1] ? 8'd0 : axes[15:8];
			p1 = a;
			p2 = b;
			if (|a)
				use_p2 = 1'b0;
			else if (|b)
				use_p2 = 1'b1;
			pl = use_p2 ? b : a;
			@(negedge clk_sys);
			ex = stick_zone(stick_x, 1'b0);
			ey = stick_zone(stick_y, 1'b1);
			if (ex == `ARC_STICK_CENTRE)
				ex = digital_pos(pl.left, pl.right);
			if (ey == `ARC_STICK_CENTRE)
				ey = digital_pos(pl.down, pl.up);
			ex = ~ex;
			ey = ~ey;
			expect_equal("sinistar_x", ex, cab.ja.stick.x);
			expect_equal("sinistar_y", ey, cab.ja.stick.y);
			expect_equal("sinistar_landscape", 0, landscape);
		end
	endtask

	task automatic plain_audio();
		logic [31:0] r;
		set_game(BUBBLES);
		repeat (20)
		begin
			r = rand_word();
			sound = r[7:0];
			speech = r[31:16];
			@(negedge clk_sys);
			expect_equal("plain_audio", mix_rule(r[7:0], r[31:16]), audio_out);
		end
	endtask

	task automatic filtered_audio();
		logic [31:0] r;
		logic [15:0] held;
		set_game(SINISTAR);
		repeat (2)
		begin
			r = rand_word();
			sound = r[7:0];
			speech = r[31:16];
			repeat (SETTLE_TICKS * `ARC_SAMPLE_DIV + 4)
				@(negedge clk_sys);
			expect_near("filtered_audio", mix_rule(r[7:0], r[31:16]));
			// The second stage only moves on the second sample tick after a step
			held = speech;
			speech = held ^ 16'h8000;
			repeat (4)
				@(negedge clk_sys);
			expect_near("filtered_lag", mix_rule(r[7:0], held));
		end
	endtask

	// Expected flags come from the counter value one cycle back
	task automatic blanking_sweep();
		int line;
		int k;
		int prev_px;
		int eff_line;
		logic exp_h;
		logic exp_v;
		logic last_ce;
		last_ce = ce_pix;
		for (line = 0; line < FRAME_LINES + 20; line++)
		begin
			for (k = 0; k < LINE_LEN; k++)
			begin
				hs = (k < 32);
				vs = ((line % FRAME_LINES) < 3);
				@(negedge clk_sys);
				prev_px = (k == 0) ? LINE_LEN - 1 : k - 1;
				eff_line = ((k == 0) ? line - 1 : line) % FRAME_LINES;
				exp_h = ((prev_px / 2) >= `ARC_HBLANK_ON) || ((prev_px / 2) < `ARC_HBLANK_OFF);
				exp_v = (eff_line >= `ARC_VBLANK_ON) || (eff_line < `ARC_VBLANK_OFF);
				if (line > 0)
				begin
					expect_equal("hblank", exp_h, hblank);
					expect_equal("ce_pix_toggle", !last_ce, ce_pix);
				end
				if (line > `ARC_VBLANK_OFF)
					expect_equal("vblank", exp_v, vblank);
				last_ce = ce_pix;
			end
		end
		hs = 1'b0;
		vs = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial
	begin
		seed = 99;
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		p1 = '0;
		p2 = '0;
		sys = '0;
		stick_x = '0;
		stick_y = '0;
		hs = 1'b0;
		vs = 1'b0;
		sound = '0;
		speech = '0;
		repeat (8)
			@(negedge clk_sys);
		rst = 1'b0;
		@(negedge clk_sys);
		expect_equal("reset_ack", 0, wb_ack);
		expect_equal("reset_audio", 0, audio_out);
		expect_equal("reset_vblank", 0, vblank);

		bus_readback();
		joust_ports();
		robotron_ports();
		sinistar_stick();
		plain_audio();
		filtered_audio();
		blanking_sweep();

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+src
src/arcade_pkg.sv
src/cfg_regs.sv
src/control_mapper.sv
src/blank_timer.sv
src/speech_iir.sv
src/audio_mixer.sv
src/arcade_io_top.sv
bench/tb_arcade_io.sv

/* src/arcade_defs.svh */
// Arcade I/O shared constants
// Bus widths, register map, blanking boundaries and speech filter coefficients

`ifndef ARCADE_DEFS_SVH
`define ARCADE_DEFS_SVH

// Wishbone config bus
`define ARC_WB_ADDR_W 2
`define ARC_WB_DATA_W 8

// Register map
`define ARC_REG_GAME 2'd0
`define ARC_REG_OPT 2'd1
`define ARC_REG_DIP 2'd2

// Video counters, horizontal bounds in half-pixel units
`define ARC_CNT_W 11
`define ARC_HBLANK_ON 10'd336
`define ARC_HBLANK_OFF 10'd40
`define ARC_VBLANK_ON 11'd254
`define ARC_VBLANK_OFF 11'd14

// Audio sample rate and one-pole low-pass (about 1800 Hz per stage)
`define ARC_AUDIO_W 16
`define ARC_SAMPLE_DIV 256
`define ARC_IIR_COEFF_W 22
`define ARC_IIR_SCALE 15
`define ARC_IIR_B 3543
`define ARC_IIR_A2 (-25682)

// 49-way stick rest position
`define ARC_STICK_CENTRE 4'd7

`endif

/* src/arcade_io_top.sv */
// Arcade I/O top level
// Config registers, control mapping, blanking and audio for the
// multi-game board wrapper

`default_nettype none
`timescale 1ns/1ps
`include "arcade_defs.svh"

module arcade_io_top (
	input  logic clk_sys,
	input  logic rst,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [`ARC_WB_ADDR_W-1:0] wb_adr,
	input  logic [`ARC_WB_DATA_W-1:0] wb_dat_w,
	output logic [`ARC_WB_DATA_W-1:0] wb_dat_r,
	output logic wb_ack,
	input  arcade_pkg::player_t p1,
	input  arcade_pkg::player_t p2,
	input  arcade_pkg::sys_buttons_t sys,
	input  arcade_pkg::stick_axis_t stick_x,
	input  arcade_pkg::stick_axis_t stick_y,
	input  logic hs,
	input  logic vs,
	input  logic [7:0] sound,
	input  logic [`ARC_AUDIO_W-1:0] speech,
	output arcade_pkg::cab_ports_t cab,
	output logic landscape,
	output logic hblank,
	output logic vblank,
	output logic ce_pix,
	output logic [`ARC_AUDIO_W-1:0] audio_out
);
	import arcade_pkg::*;

	game_e game;
	options_t opt;
	logic [`ARC_WB_DATA_W-1:0] dip;

	cfg_regs u_cfg (
		.clk_sys(clk_sys),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.game(game),
		.opt(opt),
		.dip(dip)
	);

	control_mapper u_map (
		.clk_sys(clk_sys),
		.rst(rst),
		.game(game),
		.opt(opt),
		.dip(dip),
		.p1(p1),
		.p2(p2),
		.sys(sys),
		.stick_x(stick_x),
		.stick_y(stick_y),
		.cab(cab),
		.landscape(landscape)
	);

	blank_timer u_blank (
		.clk_sys(clk_sys),
		.rst(rst),
		.hs(hs),
		.vs(vs),
		.hblank(hblank),
		.vblank(vblank),
		.ce_pix(ce_pix)
	);

	audio_mixer u_audio (
		.clk_sys(clk_sys),
		.rst(rst),
		.game(game),
		.sound(sound),
		.speech(speech),
		.audio_out(audio_out)
	);

endmodule

`default_nettype wire

/* src/arcade_pkg.sv */
// Arcade I/O types
// Game codes, player and cabinet button layouts, option bits

`default_nettype none

package arcade_pkg;

	// Board game codes; 2 and 4 belong to games not handled here
	typedef enum logic [2:0] {
		ROBOTRON = 3'd0,
		JOUST    = 3'd1,
		BUBBLES  = 3'd3,
		ALIENAR  = 3'd5,
		SINISTAR = 3'd6,
		PLAYBALL = 3'd7
	} game_e;

	// One player's controls, active high, right in bit 0
	typedef struct packed {
		logic fire_f;
		logic fire_e;
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} player_t;

	// Shared cabinet buttons
	typedef struct packed {
		logic pause_unused;
		logic autoup;
		logic advance;
		logic coin;
		logic start2;
		logic start1;
	} sys_buttons_t;

	typedef struct packed {
		logic [3:0] x;
		logic [3:0] y;
	} stick_pos_t;

	// A port byte is either raw button lines or a 49-way stick position
	typedef union packed {
		logic [7:0] buttons;
		stick_pos_t stick;
	} cab_port_u;

	typedef struct packed {
		cab_port_u ja;
		cab_port_u jb;
		logic [2:0] btn;
		logic [7:0] sw;
	} cab_ports_t;

	typedef struct packed {
		logic [5:0] reserved;
		logic twin_stick;
		logic fire_mode;
	} options_t;

	typedef logic signed [7:0] stick_axis_t;

endpackage

`default_nettype wire

/* src/audio_mixer.sv */
// Audio mixer
// Filters speech through two low-pass stages for Sinistar and sums it
// with the sound board byte

`default_nettype none
`timescale 1ns/1ps
`include "arcade_defs.svh"

module audio_mixer (
	input  logic clk_sys,
	input  logic rst,
	input  arcade_pkg::game_e game,
	input  logic [7:0] sound,
	input  logic [`ARC_AUDIO_W-1:0] speech,
	output logic [`ARC_AUDIO_W-1:0] audio_out
);
	import arcade_pkg::*;

	logic signed [`ARC_AUDIO_W-1:0] speech_s;
	logic signed [`ARC_AUDIO_W-1:0] stage1;
	logic signed [`ARC_AUDIO_W-1:0] stage2;
	logic [`ARC_AUDIO_W-1:0] speech_f;
	logic [`ARC_AUDIO_W-1:0] speech_sel;
	logic [`ARC_AUDIO_W:0] sum;

	// Offset binary to two's complement, i.e. subtract 0x8000
	assign speech_s = {~speech[`ARC_AUDIO_W-1], speech[`ARC_AUDIO_W-2:0]};

	// Two stages roughly match the RC cascade on the speech board
	speech_iir #(.DATA_W(`ARC_AUDIO_W)) u_lpf1 (
		.clk_sys(clk_sys),
		.rst(rst),
		.din(speech_s),
		.dout(stage1)
	);

	speech_iir #(.DATA_W(`ARC_AUDIO_W)) u_lpf2 (
		.clk_sys(clk_sys),
		.rst(rst),
		.din(stage1),
		.dout(stage2)
	);

	assign speech_f = {~stage2[`ARC_AUDIO_W-1], stage2[`ARC_AUDIO_W-2:0]};
	assign speech_sel = (game == SINISTAR) ? speech_f : speech;
	assign sum = {1'b0, sound, 8'd0} + {1'b0, speech_sel};

	// Keep sum bits 16..3, leaving headroom at the top
	always_ff @(posedge clk_sys)
	begin
		if (rst)
			audio_out <= '0;
		else
			audio_out <= {2'b00, sum[`ARC_AUDIO_W:3]};
	end

endmodule

`default_nettype wire

/* src/blank_timer.sv */
// Blanking generator
// Counts half-pixels and lines from the board sync pulses and
// produces the blank flags and pixel enable

`default_nettype none
`timescale 1ns/1ps
`include "arcade_defs.svh"

module blank_timer (
	input  logic clk_sys,
	input  logic rst,
	input  logic hs,
	input  logic vs,
	output logic hblank,
	output logic vblank,
	output logic ce_pix
);

	logic hs_q;
	logic vs_q;
	logic hs_rise;
	logic [`ARC_CNT_W-1:0] pcnt;
	logic [`ARC_CNT_W-1:0] lcnt;

	assign hs_rise = hs & ~hs_q;

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			hs_q <= 1'b0;
			vs_q <= 1'b0;
			pcnt <= '0;
			lcnt <= '0;
			hblank <= 1'b0;
			vblank <= 1'b0;
		end
		else
		begin
			hs_q <= hs;
			if (hs_rise)
			begin
				pcnt <= '0;
				if (~&lcnt)
					lcnt <= lcnt + 1'b1;
				// vs is only looked at on line starts
				vs_q <= vs;
				if (vs & ~vs_q)
					lcnt <= '0;
			end
			else if (~&pcnt)
				pcnt <= pcnt + 1'b1;

			if (pcnt[`ARC_CNT_W-1:1] == `ARC_HBLANK_ON)
				hblank <= 1'b1;
			if (pcnt[`ARC_CNT_W-1:1] == `ARC_HBLANK_OFF)
				hblank <= 1'b0;

			if (lcnt == `ARC_VBLANK_ON)
				vblank <= 1'b1;
			if (lcnt == `ARC_VBLANK_OFF)
				vblank <= 1'b0;
		end
	end

	// Pixels run at half the system clock
	assign ce_pix = pcnt[0];

endmodule

`default_nettype wire

/* src/cfg_regs.sv */
// Configuration registers
// Wishbone classic slave with game select, control options and DIP bank 0

`default_nettype none
`timescale 1ns/1ps
`include "arcade_defs.svh"

module cfg_regs (
	input  logic clk_sys,
	input  logic rst,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [`ARC_WB_ADDR_W-1:0] wb_adr,
	input  logic [`ARC_WB_DATA_W-1:0] wb_dat_w,
	output logic [`ARC_WB_DATA_W-1:0] wb_dat_r,
	output logic wb_ack,
	output arcade_pkg::game_e game,
	output arcade_pkg::options_t opt,
	output logic [`ARC_WB_DATA_W-1:0] dip
);
	import arcade_pkg::*;

	logic [2:0] game_q;
	logic access;

	// One access per strobe; ack drops for a cycle even if stb stays up
	assign access = wb_cyc & wb_stb & ~wb_ack;

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			wb_ack <= 1'b0;
			game_q <= 3'd0;
			opt <= '0;
			dip <= '0;
		end
		else
		begin
			wb_ack <= access;
			if (access & wb_we)
			begin
				case (wb_adr)
					`ARC_REG_GAME: game_q <= wb_dat_w[2:0];
					`ARC_REG_OPT: opt <= options_t'(wb_dat_w);
					`ARC_REG_DIP: dip <= wb_dat_w;
					default: ;
				endcase
			end
		end
	end

	// Read data captured alongside ack
	always_ff @(posedge clk_sys)
	begin
		if (access)
		begin
			case (wb_adr)
				`ARC_REG_GAME: wb_dat_r <= {5'd0, game_q};
				`ARC_REG_OPT: wb_dat_r <= opt;
				`ARC_REG_DIP: wb_dat_r <= dip;
				default: wb_dat_r <= '0;
			endcase
		end
	end

	// Codes outside the enum are kept as written
	assign game = game_e'(game_q);

endmodule

`default_nettype wire

/* src/control_mapper.sv */
// Control mapper
// Builds the active-low JA, JB and BTN cabinet ports for each game,
// including the quantized analog stick used by Sinistar

`default_nettype none
`timescale 1ns/1ps
`include "arcade_defs.svh"

module control_mapper (
	input  logic clk_sys,
	input  logic rst,
	input  arcade_pkg::game_e game,
	input  arcade_pkg::options_t opt,
	input  logic [7:0] dip,
	input  arcade_pkg::player_t p1,
	input  arcade_pkg::player_t p2,
	input  arcade_pkg::sys_buttons_t sys,
	input  arcade_pkg::stick_axis_t stick_x,
	input  arcade_pkg::stick_axis_t stick_y,
	output arcade_pkg::cab_ports_t cab,
	output logic landscape
);
	import arcade_pkg::*;

	localparam cab_ports_t IDLE_CAB = {8'hFF, 8'hFF, 3'b111, 8'h00};

	player_t both;
	player_t last_pl;
	logic last_p2_q;
	logic last_p2_d;
	logic [3:0] rob_hi;
	logic [3:0] rob_lo;
	logic [3:0] amx;
	logic [3:0] amy;
	logic [3:0] dmx;
	logic [3:0] dmy;
	cab_ports_t cab_d;
	logic landscape_d;

	// Move nibble in board order: right, left, down, up
	function automatic logic [3:0] move_of(input player_t p);
		return {p.right, p.left, p.down, p.up};
	endfunction

	// 49-way stick table; y runs the other way round
	function automatic logic [3:0] quantize(input stick_axis_t axis, input logic mirror);
		logic [3:0] neg_far;
		logic [3:0] neg_mid;
		logic [3:0] neg_near;
		logic [3:0] pos_far;
		logic [3:0] pos_mid;
		logic [3:0] pos_near;
		neg_far = mirror ? 4'd8 : 4'd0;
		neg_mid = mirror ? 4'd9 : 4'd4;
		neg_near = mirror ? 4'd11 : 4'd6;
		pos_far = mirror ? 4'd0 : 4'd8;
		pos_mid = mirror ? 4'd4 : 4'd9;
		pos_near = mirror ? 4'd6 : 4'd11;
		if (axis < -96) return neg_far;
		else if (axis < -64) return neg_mid;
		else if (axis < -32) return neg_near;
		else if (axis > 96) return pos_far;
		else if (axis > 64) return pos_mid;
		else if (axis > 32) return pos_near;
		return `ARC_STICK_CENTRE;
	endfunction

	assign both = p1 | p2;

	// Last player to touch anything owns the stick, player 1 wins a tie
	assign last_p2_d = (|p1) ? 1'b0 : (|p2) ? 1'b1 : last_p2_q;
	assign last_pl = last_p2_d ? p2 : p1;

	assign amx = quantize(stick_x, 1'b0);
	assign amy = quantize(stick_y, 1'b1);
	assign dmx = last_pl.left ? 4'd0 : last_pl.right ? 4'd8 : `ARC_STICK_CENTRE;
	assign dmy = last_pl.down ? 4'd0 : last_pl.up ? 4'd8 : `ARC_STICK_CENTRE;

	// Robotron: twin stick, move plus fire, or the four fire buttons
	assign rob_hi = opt.twin_stick ? move_of(p2) :
		opt.fire_mode ? move_of(both) : {both.fire_a, both.fire_d, both.fire_b, both.fire_c};
	assign rob_lo = opt.twin_stick ? move_of(p1) : move_of(both);

	always_comb
	begin
		cab_d = IDLE_CAB;
		cab_d.sw = dip | {6'd0, sys.advance, sys.autoup};
		landscape_d = 1'b1;
		case (game)
			ROBOTRON:
			begin
				cab_d.btn = ~{sys.start1, sys.start2, sys.coin};
				cab_d.ja.buttons = ~{rob_hi, rob_lo};
				cab_d.jb = cab_d.ja;
			end
			JOUST:
			begin
				cab_d.btn = ~{sys.start2, sys.start1, sys.coin};
				cab_d.ja.buttons = ~{5'd0, p1.fire_a, p1.right, p1.left};
				cab_d.jb.buttons = ~{5'd0, p2.fire_a, p2.right, p2.left};
			end
			BUBBLES:
			begin
				cab_d.btn = ~{sys.start2, sys.start1, sys.coin};
				cab_d.ja.buttons = ~{4'd0, move_of(both)};
				cab_d.jb = cab_d.ja;
			end
			ALIENAR:
			begin
				cab_d.btn = ~{sys.start1, sys.start2, sys.coin};
				cab_d.ja.buttons = ~{2'd0, p1.fire_b, p1.fire_a, move_of(p1)};
				cab_d.jb.buttons = ~{2'd0, p2.fire_b, p2.fire_a, move_of(p2)};
			end
			SINISTAR:
			begin
				cab_d.btn = ~{sys.start1, sys.start2, sys.coin};
				// Digital directions only when the analog stick rests
				cab_d.ja.stick.x = ~((amx == `ARC_STICK_CENTRE) ? dmx : amx);
				cab_d.ja.stick.y = ~((amy == `ARC_STICK_CENTRE) ? dmy : amy);
				cab_d.jb = cab_d.ja;
				landscape_d = 1'b0;
			end
			PLAYBALL:
			begin
				cab_d.btn = ~{2'd0, sys.coin};
				cab_d.ja.buttons = ~{4'd0, sys.start2, both.right, both.left, sys.start1};
				cab_d.jb = cab_d.ja;
				landscape_d = 1'b0;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			last_p2_q <= 1'b0;
			cab <= IDLE_CAB;
			landscape <= 1'b1;
		end
		else
		begin
			last_p2_q <= last_p2_d;
			cab <= cab_d;
			landscape <= landscape_d;
		end
	end

endmodule

`default_nettype wire

/* src/speech_iir.sv */
// Speech low-pass stage
// First-order IIR with unity DC gain, stepped once per audio sample
// by its own clock divider

`default_nettype none
`timescale 1ns/1ps
`include "arcade_defs.svh"

module speech_iir #(
	parameter int DATA_W = 16
) (
	input  logic clk_sys,
	input  logic rst,
	input  logic signed [DATA_W-1:0] din,
	output logic signed [DATA_W-1:0] dout
);

	localparam int COEFF_W = `ARC_IIR_COEFF_W;
	localparam int ACC_W = DATA_W + COEFF_W + 2;
	localparam int DIV_W = $clog2(`ARC_SAMPLE_DIV);
	localparam logic signed [COEFF_W-1:0] COEFF_B = `ARC_IIR_B;
	localparam logic signed [COEFF_W-1:0] COEFF_A2 = `ARC_IIR_A2;

	logic [DIV_W-1:0] div_cnt;
	logic tick;
	logic signed [DATA_W-1:0] x_prev;
	logic signed [ACC_W-1:0] acc;

	//////////////////////////////////////////////////
	// Sample rate divider
	//////////////////////////////////////////////////

	assign tick = (div_cnt == DIV_W'(`ARC_SAMPLE_DIV - 1));

	always_ff @(posedge clk_sys)
	begin
		if (rst || tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	//////////////////////////////////////////////////
	// y = (b*x + b*x1 - a2*y1) / 2^scale
	//////////////////////////////////////////////////

	// 2*b - a2 equals 2^scale, so DC passes unchanged
	assign acc = COEFF_B * din + COEFF_B * x_prev - COEFF_A2 * dout;

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			x_prev <= '0;
			dout <= '0;
		end
		else if (tick)
		begin
			x_prev <= din;
			dout <= acc[`ARC_IIR_SCALE +: DATA_W];
		end
	end

endmodule

`default_nettype wire
